//--- Makefile
# Verilator build for the PMP testbench

VERILATOR ?= verilator
TOP       ?= pmp_tb
RTL_TOP   ?= pmp_top
FILE_LIST ?= files.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j $(JOBS)
LINTFLAGS ?= --lint-only -Wall --timing --timescale 1ns/1ps

SOURCES := $(wildcard logic/*.sv logic/*.svh sim/*.sv)
RTL_SRC := logic/pmp_rule_pkg.sv logic/pmp_access_pkg.sv logic/pmp_rule_decode.sv \
           logic/pmp_region_match.sv logic/pmp_data_port.sv logic/pmp_fetch_port.sv \
           logic/pmp_top.sv

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILE_LIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) +incdir+logic --top-module $(RTL_TOP) $(RTL_SRC)
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILE_LIST)

clean:
	rm -rf $(BUILD_DIR)

//--- files.f
+incdir+logic
logic/pmp_rule_pkg.sv
logic/pmp_access_pkg.sv
logic/pmp_rule_decode.sv
logic/pmp_region_match.sv
logic/pmp_data_port.sv
logic/pmp_fetch_port.sv
logic/pmp_top.sv
sim/pmp_tb.sv

//--- logic/pmp_access_pkg.sv
/* PMP access types */

package pmp_access_pkg;

   // privilege level of the core, H is not supported
   typedef enum logic [1:0]
   {
      U = 2'd0,
      S = 2'd1,
      M = 2'd3
   } priv_lvl_e;

   //////////////////////
   // data error FSM
   //////////////////////

   // GIVE_ERROR holds data_err_o until the core acks it
   typedef enum logic
   {
      IDLE       = 1'b0,
      GIVE_ERROR = 1'b1
   } data_err_state_e;

endpackage

//--- logic/pmp_data_port.sv
/* PMP data port */

`timescale 1ns/1ps

`include "pmp_defines.svh"

module pmp_data_port
   import pmp_rule_pkg::*;
   import pmp_access_pkg::*;
(
   input  logic                           clk,
   input  logic                           rst_n,
   input  priv_lvl_e                      priv_lvl_i,
   input  pmp_region_t [`PMP_ENTRIES-1:0] regions_i,
   input  logic        [`PMP_ENTRIES-1:0] hit_i,
   // core side
   input  logic                           data_req_i,
   input  logic                           data_we_i,
   output logic                           data_gnt_o,
   // memory side
   output logic                           data_req_o,
   input  logic                           data_gnt_i,
   // error towards the core
   output logic                           data_err_o,
   input  logic                           data_err_ack_i
);

   logic [`PMP_ENTRIES-1:0] perm_hit;
   logic                    allowed;
   logic                    deny_req;
   data_err_state_e         state_q;
   data_err_state_e         state_d;

   //////////////////////
   // permission check
   //////////////////////

   // reads need r, writes need w
   always_comb
   begin
      for (int i = 0; i < `PMP_ENTRIES; i++)
      begin
         perm_hit[i] = hit_i[i] & (data_we_i ? regions_i[i].w : regions_i[i].r);
      end
   end

   // machine mode bypasses the table
   assign allowed  = (priv_lvl_i == M) || (|perm_hit);
   assign deny_req = data_req_i & ~allowed;

   assign data_req_o = data_req_i & allowed;
   assign data_gnt_o = data_gnt_i & allowed;

   //////////////////////
   // error FSM
   //////////////////////

   always_comb
   begin
      state_d = state_q;
      case (state_q)
         IDLE:
         begin
            if (deny_req)
               state_d = GIVE_ERROR;
         end
         GIVE_ERROR:
         begin
            // further denied requests are absorbed until the ack
            if (data_err_ack_i)
               state_d = IDLE;
         end
         default:
         begin
            state_d = IDLE;
         end
      endcase
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         state_q <= IDLE;
      else
         state_q <= state_d;
   end

   assign data_err_o = (state_q == GIVE_ERROR);

   // a disabled entry never reports a hit
   for (genvar i = 0; i < `PMP_ENTRIES; i++)
   begin : g_hit_chk
      a_hit_needs_en: assert property (@(posedge clk) disable iff (!rst_n)
         hit_i[i] |-> regions_i[i].en);
   end

   // the error only clears after the core has acknowledged it
   a_err_clears_on_ack: assert property (@(posedge clk) disable iff (!rst_n)
      $fell(data_err_o) |-> $past(data_err_ack_i));

endmodule

//--- logic/pmp_defines.svh
/* PMP sizing macros */

`ifndef PMP_DEFINES_SVH
`define PMP_DEFINES_SVH

//////////////////////
// table and address sizes
//////////////////////

// number of rule entries in the table
`define PMP_ENTRIES 16

// byte address width on both paths
`define PMP_ADDR_W 32

// rules and matchers work on word addresses
`define PMP_WADDR_W (`PMP_ADDR_W - 2)

// largest trailing-ones count accepted in a NAPOT address
// 15 gives 256 KB regions at most
`define PMP_NAPOT_MAX_T 15

`endif

//--- logic/pmp_fetch_port.sv
/* PMP fetch port */

`timescale 1ns/1ps

`include "pmp_defines.svh"

module pmp_fetch_port
   import pmp_rule_pkg::*;
   import pmp_access_pkg::*;
(
   input  priv_lvl_e                      priv_lvl_i,
   input  pmp_region_t [`PMP_ENTRIES-1:0] regions_i,
   input  logic        [`PMP_ENTRIES-1:0] hit_i,
   // core side
   input  logic                           instr_req_i,
   output logic                           instr_gnt_o,
   // memory side
   output logic                           instr_req_o,
   input  logic                           instr_gnt_i,
   output logic                           instr_err_o
);

   logic [`PMP_ENTRIES-1:0] exec_hit;
   logic                    allowed;

   // fetches need x on a matching entry
   always_comb
   begin
      for (int i = 0; i < `PMP_ENTRIES; i++)
      begin
         exec_hit[i] = hit_i[i] & regions_i[i].x;
      end
   end

   assign allowed = (priv_lvl_i == M) || (|exec_hit);

   assign instr_req_o = instr_req_i & allowed;
   assign instr_gnt_o = instr_gnt_i & allowed;
   // denial is reported in the same cycle as the request
   assign instr_err_o = instr_req_i & ~allowed;

endmodule

//--- logic/pmp_region_match.sv
/* PMP region matcher */

`timescale 1ns/1ps

`include "pmp_defines.svh"

module pmp_region_match
   import pmp_rule_pkg::*;
(
   input  pmp_region_t [`PMP_ENTRIES-1:0] regions_i,
   input  pmp_waddr_t                     addr_i,
   output logic        [`PMP_ENTRIES-1:0] hit_o
);

   //////////////////////
   // address compare
   //////////////////////

   // permissions are checked by the ports, only the address is compared here
   always_comb
   begin
      for (int i = 0; i < `PMP_ENTRIES; i++)
      begin
         hit_o[i] = 1'b0;
         if (regions_i[i].en)
         begin
            case (regions_i[i].mode)
               TOR:
               begin
                  // upper bound is exclusive
                  hit_o[i] = (addr_i >= regions_i[i].base) &&
                             (addr_i < regions_i[i].top);
               end
               NA4:
               begin
                  hit_o[i] = (addr_i == regions_i[i].base);
               end
               NAPOT:
               begin
                  hit_o[i] = ((addr_i & regions_i[i].mask) == regions_i[i].base);
               end
               default:
               begin
                  hit_o[i] = 1'b0;
               end
            endcase
         end
      end
   end

endmodule

//--- logic/pmp_rule_decode.sv
/* PMP rule decoder */

`timescale 1ns/1ps

`include "pmp_defines.svh"

module pmp_rule_decode
   import pmp_rule_pkg::*;
(
   input  pmp_waddr_t  [`PMP_ENTRIES-1:0] pmp_addr_i,
   input  pmp_cfg_t    [`PMP_ENTRIES-1:0] pmp_cfg_i,
   output pmp_region_t [`PMP_ENTRIES-1:0] regions_o
);

   // number of consecutive ones starting at bit 0
   function automatic int unsigned count_trailing_ones(input pmp_waddr_t addr);
      int unsigned cnt;
      logic        run;
      cnt = 0;
      run = 1'b1;
      for (int b = 0; b < `PMP_WADDR_W; b++)
      begin
         run = run & addr[b];
         if (run)
            cnt = cnt + 1;
      end
      return cnt;
   endfunction

   for (genvar i = 0; i < `PMP_ENTRIES; i++)
   begin : g_entry
      pmp_waddr_t  prev_addr;
      int unsigned napot_t;
      pmp_region_t dec;

      // TOR takes its lower bound from the entry below, entry 0 starts at zero
      if (i == 0)
      begin : g_first
         assign prev_addr = '0;
      end
      else
      begin : g_rest
         assign prev_addr = pmp_addr_i[i-1];
      end

      assign napot_t = count_trailing_ones(pmp_addr_i[i]);

      always_comb
      begin
         dec      = '0;
         dec.mode = pmp_cfg_i[i].mode;
         dec.r    = pmp_cfg_i[i].r;
         dec.w    = pmp_cfg_i[i].w;
         dec.x    = pmp_cfg_i[i].x;
         dec.mask = '1;

         case (pmp_cfg_i[i].mode)
            TOR:
            begin
               dec.en   = 1'b1;
               dec.base = prev_addr;
               dec.top  = pmp_addr_i[i];
            end
            NA4:
            begin
               dec.en   = 1'b1;
               dec.base = pmp_addr_i[i];
               dec.top  = pmp_addr_i[i];
            end
            NAPOT:
            begin
               // t trailing ones give a block of 2^(t+1) words
               dec.en   = (napot_t <= `PMP_NAPOT_MAX_T);
               dec.mask = pmp_waddr_t'('1) << (napot_t + 1);
               dec.base = pmp_addr_i[i] & dec.mask;
               dec.top  = pmp_addr_i[i];
            end
            default:
            begin
               dec.en = 1'b0;
            end
         endcase
      end

      assign regions_o[i] = dec;
   end

endmodule

//--- logic/pmp_rule_pkg.sv
/* PMP rule types */

`include "pmp_defines.svh"

package pmp_rule_pkg;

   //////////////////////
   // raw rule fields
   //////////////////////

   // address matching mode of one entry
   typedef enum logic [1:0]
   {
      OFF   = 2'd0,
      TOR   = 2'd1,
      NA4   = 2'd2,
      NAPOT = 2'd3
   } pmp_mode_e;

   // configuration byte, lock and reserved bits are ignored
   typedef struct packed
   {
      logic [2:0] unused;
      pmp_mode_e  mode;
      logic       x;
      logic       w;
      logic       r;
   } pmp_cfg_t;

   typedef logic [`PMP_WADDR_W-1:0] pmp_waddr_t;

   //////////////////////
   // decoded entry
   //////////////////////

   typedef struct packed
   {
      logic       en;
      pmp_mode_e  mode;
      logic       r;
      logic       w;
      logic       x;
      pmp_waddr_t base;
      pmp_waddr_t top;
      pmp_waddr_t mask;
   } pmp_region_t;

endpackage

//--- logic/pmp_top.sv
/* PMP top level */

`timescale 1ns/1ps

`include "pmp_defines.svh"

module pmp_top
   import pmp_rule_pkg::*;
   import pmp_access_pkg::*;
(
   input  logic                          clk,
   input  logic                          rst_n,
   input  priv_lvl_e                     priv_lvl_i,
   input  pmp_waddr_t [`PMP_ENTRIES-1:0] pmp_addr_i,
   input  pmp_cfg_t   [`PMP_ENTRIES-1:0] pmp_cfg_i,
   // data path, core side
   input  logic                          data_req_i,
   input  logic       [`PMP_ADDR_W-1:0]  data_addr_i,
   input  logic                          data_we_i,
   output logic                          data_gnt_o,
   // data path, memory side
   output logic                          data_req_o,
   input  logic                          data_gnt_i,
   output logic       [`PMP_ADDR_W-1:0]  data_addr_o,
   output logic                          data_err_o,
   input  logic                          data_err_ack_i,
   // fetch path, core side
   input  logic                          instr_req_i,
   input  logic       [`PMP_ADDR_W-1:0]  instr_addr_i,
   output logic                          instr_gnt_o,
   // fetch path, memory side
   output logic                          instr_req_o,
   input  logic                          instr_gnt_i,
   output logic       [`PMP_ADDR_W-1:0]  instr_addr_o,
   output logic                          instr_err_o
);

   pmp_region_t [`PMP_ENTRIES-1:0] regions;
   logic        [`PMP_ENTRIES-1:0] data_hit;
   logic        [`PMP_ENTRIES-1:0] instr_hit;

   // addresses are never modified
   assign data_addr_o  = data_addr_i;
   assign instr_addr_o = instr_addr_i;

   pmp_rule_decode u_decode (
      .pmp_addr_i (pmp_addr_i),
      .pmp_cfg_i  (pmp_cfg_i),
      .regions_o  (regions)
   );

   //////////////////////
   // data path
   //////////////////////

   pmp_region_match u_data_match (
      .regions_i (regions),
      .addr_i    (data_addr_i[`PMP_ADDR_W-1:2]),
      .hit_o     (data_hit)
   );

   pmp_data_port u_data_port (
      .clk            (clk),
      .rst_n          (rst_n),
      .priv_lvl_i     (priv_lvl_i),
      .regions_i      (regions),
      .hit_i          (data_hit),
      .data_req_i     (data_req_i),
      .data_we_i      (data_we_i),
      .data_gnt_o     (data_gnt_o),
      .data_req_o     (data_req_o),
      .data_gnt_i     (data_gnt_i),
      .data_err_o     (data_err_o),
      .data_err_ack_i (data_err_ack_i)
   );

   //////////////////////
   // fetch path
   //////////////////////

   pmp_region_match u_instr_match (
      .regions_i (regions),
      .addr_i    (instr_addr_i[`PMP_ADDR_W-1:2]),
      .hit_o     (instr_hit)
   );

   pmp_fetch_port u_fetch_port (
      .priv_lvl_i  (priv_lvl_i),
      .regions_i   (regions),
      .hit_i       (instr_hit),
      .instr_req_i (instr_req_i),
      .instr_gnt_o (instr_gnt_o),
      .instr_req_o (instr_req_o),
      .instr_gnt_i (instr_gnt_i),
      .instr_err_o (instr_err_o)
   );

endmodule

//--- sim/pmp_tb.sv
/* PMP testbench */

`timescale 1ns/1ps

`include "pmp_defines.svh"

module pmp_tb
   import pmp_rule_pkg::*;
   import pmp_access_pkg::*;
();

   // stimulus below runs roughly 2000 cycles
   localparam int TIMEOUT_CYCLES = 6000;
   localparam int KIND_READ      = 0;
   localparam int KIND_WRITE     = 1;
   localparam int KIND_FETCH     = 2;

   logic                          clk;
   logic                          rst_n;
   priv_lvl_e                     priv_lvl_i;
   pmp_waddr_t [`PMP_ENTRIES-1:0] pmp_addr_i;
   pmp_cfg_t   [`PMP_ENTRIES-1:0] pmp_cfg_i;
   logic                          data_req_i;
   logic [31:0]                   data_addr_i;
   logic                          data_we_i;
   logic                          data_gnt_o;
   logic                          data_req_o;
   logic                          data_gnt_i;
   logic [31:0]                   data_addr_o;
   logic                          data_err_o;
   logic                          data_err_ack_i;
   logic                          instr_req_i;
   logic [31:0]                   instr_addr_i;
   logic                          instr_gnt_o;
   logic                          instr_req_o;
   logic                          instr_gnt_i;
   logic [31:0]                   instr_addr_o;
   logic                          instr_err_o;
   logic                          err_model;
   int                            cycle_cnt = 0;

   pmp_top DUT (.*);

   initial clk = 1'b0;
   always #5 clk = ~clk;

   //////////////////////
   // reference model
   //////////////////////

   // any enabled entry that matches and grants the right bit allows the access
   function automatic bit ref_allowed(input logic [31:0] byte_addr, input int kind,
                                      input priv_lvl_e priv);
      logic [63:0] word;
      logic [63:0] cur;
      logic [63:0] lo;
      logic [63:0] size;
      int          t;
      bit          hit;
      bit          perm;
      bit          grant;
      grant = 1'b0;
      word  = {34'd0, byte_addr[31:2]};
      if (priv == M)
         return 1'b1;
      for (int i = 0; i < `PMP_ENTRIES; i++)
      begin
         cur = {34'd0, pmp_addr_i[i]};
         hit = 1'b0;
         lo  = 64'd0;
         case (pmp_cfg_i[i].mode)
            TOR:
            begin
               if (i != 0)
                  lo = {34'd0, pmp_addr_i[i-1]};
               hit = (word >= lo) && (word < cur);
            end
            NA4:
               hit = (word == cur);
            NAPOT:
            begin
               t = 0;
               while (t < `PMP_WADDR_W && cur[t])
                  t++;
               // block of 2^(t+1) words, aligned to its own size
               size = 64'd1 << (t + 1);
               lo   = cur & ~(size - 64'd1);
               hit  = (t <= `PMP_NAPOT_MAX_T) && (word >= lo) && (word < lo + size);
            end
            default:
               hit = 1'b0;
         endcase
         if (kind == KIND_READ)
            perm = pmp_cfg_i[i].r;
         else if (kind == KIND_WRITE)
            perm = pmp_cfg_i[i].w;
         else
            perm = pmp_cfg_i[i].x;
         if (hit && perm)
            grant = 1'b1;
      end
      return grant;
   endfunction

   // data error is raised by a denied request in idle and cleared by ack
   always @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         err_model <= 1'b0;
      else if (err_model)
      begin
         if (data_err_ack_i)
            err_model <= 1'b0;
      end
      else if (data_req_i &&
               !ref_allowed(data_addr_i, data_we_i ? KIND_WRITE : KIND_READ, priv_lvl_i))
         err_model <= 1'b1;
   end

   //////////////////////
   // checking
   //////////////////////

   task automatic compare(input logic [31:0] got, input logic [31:0] exp, input string what);
      if (got !== exp)
      begin
         $display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
         $display("Test failed");
         $fatal(1, "stopping at the first mismatch");
      end
   endtask

   task automatic check_outputs();
      bit data_ok;
      bit instr_ok;
      data_ok  = ref_allowed(data_addr_i, data_we_i ? KIND_WRITE : KIND_READ, priv_lvl_i);
      instr_ok = ref_allowed(instr_addr_i, KIND_FETCH, priv_lvl_i);
      compare(32'(data_req_o), 32'(data_req_i & data_ok), "data_req_o");
      compare(32'(data_gnt_o), 32'(data_gnt_i & data_ok), "data_gnt_o");
      compare(data_addr_o, data_addr_i, "data_addr_o");
      compare(32'(data_err_o), 32'(err_model), "data_err_o");
      compare(32'(instr_req_o), 32'(instr_req_i & instr_ok), "instr_req_o");
      compare(32'(instr_gnt_o), 32'(instr_gnt_i & instr_ok), "instr_gnt_o");
      compare(32'(instr_err_o), 32'(instr_req_i & !instr_ok), "instr_err_o");
      compare(instr_addr_o, instr_addr_i, "instr_addr_o");
   endtask

   // inputs change on the falling edge, outputs are sampled 1 ns before the rising edge
   always @(negedge clk)
   begin
      #4;
      if (rst_n)
         check_outputs();
   end

   always @(posedge clk)
   begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYCLES)
      begin
         $display("Test failed");
         $fatal(1, "timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      end
   end

   //////////////////////
   // stimulus
   //////////////////////

   task automatic fill_table(input bit mixed);
      int unsigned base;
      int unsigned t;
      for (int i = 0; i < `PMP_ENTRIES; i++)
      begin
         pmp_cfg_i[i].r      = 1'($urandom);
         pmp_cfg_i[i].w      = 1'($urandom);
         pmp_cfg_i[i].x      = 1'($urandom);
         pmp_cfg_i[i].unused = 3'($urandom);
         pmp_cfg_i[i].mode   = pmp_mode_e'(2'($urandom));
         pmp_addr_i[i]       = pmp_waddr_t'($urandom);
         if (mixed)
         begin
            // small window so that entries overlap and accesses land on them
            base = $urandom_range(32'h3fff, 0);
            t    = $urandom_range(10, 0);
            if (pmp_cfg_i[i].mode == NAPOT)
               base = (base & ~((32'd1 << (t + 1)) - 32'd1)) | ((32'd1 << t) - 32'd1);
            pmp_addr_i[i] = pmp_waddr_t'(base);
         end
      end
      if (mixed)
         pmp_cfg_i[0].mode = TOR;
   endtask

   // favours entry addresses and their neighbours, i.e. TOR base and top edges
   function automatic logic [31:0] pick_addr();
      int unsigned j;
      int unsigned word;
      j = $urandom_range(`PMP_ENTRIES - 1, 0);
      case ($urandom_range(4, 0))
         0: word = {2'b00, pmp_addr_i[j]};
         1: word = {2'b00, pmp_addr_i[j]} - 32'd1;
         2: word = {2'b00, pmp_addr_i[j]} + 32'd1;
         3:
         begin
            word = 32'd0;
            if (j != 0)
               word = {2'b00, pmp_addr_i[j-1]};
         end
         default: word = $urandom_range(32'h3fff, 0);
      endcase
      return {word[29:0], 2'($urandom)};
   endfunction

   task automatic run_random(input priv_lvl_e lvl, input int tables, input int cycles,
                             input bit mixed);
      for (int n = 0; n < tables; n++)
      begin
         for (int c = 0; c < cycles; c++)
         begin
            @(negedge clk);
            if (c == 0)
               fill_table(mixed);
            priv_lvl_i     = lvl;
            data_req_i     = 1'($urandom);
            data_we_i      = 1'($urandom);
            data_gnt_i     = 1'($urandom);
            data_err_ack_i = ($urandom_range(2, 0) == 0);
            instr_req_i    = 1'($urandom);
            instr_gnt_i    = 1'($urandom);
            data_addr_i    = mixed ? pick_addr() : $urandom;
            instr_addr_i   = mixed ? pick_addr() : $urandom;
         end
      end
   endtask

   // every data access is denied with an empty table in user mode
   task automatic run_error_hold();
      int unsigned hold;
      @(negedge clk);
      pmp_cfg_i      = '0;
      priv_lvl_i     = U;
      data_req_i     = 1'b0;
      data_err_ack_i = 1'b1;
      for (int n = 0; n < 20; n++)
      begin
         @(negedge clk);
         data_err_ack_i = 1'b0;
         data_req_i     = 1'b1;
         data_we_i      = 1'($urandom);
         data_addr_i    = $urandom;
         hold           = $urandom_range(8, 1);
         @(negedge clk);
         compare(32'(data_err_o), 32'd1, "data_err_o after a denied request");
         repeat (hold)
         begin
            data_req_i  = 1'($urandom);
            data_addr_i = $urandom;
            @(negedge clk);
            compare(32'(data_err_o), 32'd1, "data_err_o while waiting for ack");
         end
         data_req_i     = 1'b0;
         data_err_ack_i = 1'b1;
         @(negedge clk);
         compare(32'(data_err_o), 32'd0, "data_err_o after ack");
      end
   endtask

   task automatic run_napot_sizes();
      int unsigned size;
      int unsigned lo;
      int unsigned probe [5];
      bit          inside_blk;
      priv_lvl_i     = U;
      data_err_ack_i = 1'b1;
      data_req_i     = 1'b1;
      instr_req_i    = 1'b1;
      for (int t = 0; t <= `PMP_NAPOT_MAX_T + 2; t++)
      begin
         for (int off = 0; off < 2; off++)
         begin
            size     = 32'd1 << (t + 1);
            lo       = size * $urandom_range(3, 1);
            probe[0] = lo;
            probe[1] = lo + size - 32'd1;
            probe[2] = lo - 32'd1;
            probe[3] = lo + size;
            probe[4] = lo + $urandom_range(size - 32'd1, 0);
            for (int p = 0; p < 5; p++)
            begin
               @(negedge clk);
               pmp_cfg_i           = '0;
               pmp_addr_i          = '0;
               pmp_addr_i[5]       = pmp_waddr_t'(lo | ((size >> 1) - 32'd1));
               pmp_cfg_i[5].mode   = (off == 0) ? NAPOT : OFF;
               pmp_cfg_i[5].r      = 1'b1;
               pmp_cfg_i[5].w      = 1'b1;
               pmp_cfg_i[5].x      = 1'b1;
               data_we_i           = 1'($urandom);
               data_addr_i         = {probe[p][29:0], 2'($urandom)};
               instr_addr_i        = {probe[p][29:0], 2'b00};
               inside_blk          = (p == 0) || (p == 1) || (p == 4);
               #4;
               compare(32'(instr_err_o),
                       32'(!(inside_blk && off == 0 && t <= `PMP_NAPOT_MAX_T)),
                       "instr_err_o on a NAPOT probe");
            end
         end
      end
   endtask

   initial
   begin
      void'($urandom(81));
      rst_n          = 1'b0;
      priv_lvl_i     = M;
      pmp_addr_i     = '0;
      pmp_cfg_i      = '0;
      data_req_i     = 1'b0;
      data_addr_i    = '0;
      data_we_i      = 1'b0;
      data_gnt_i     = 1'b0;
      data_err_ack_i = 1'b0;
      instr_req_i    = 1'b0;
      instr_addr_i   = '0;
      instr_gnt_i    = 1'b0;
      repeat (10) @(negedge clk);
      rst_n = 1'b1;
      run_random(M, 6, 50, 1'b0);
      run_random(U, 8, 100, 1'b1);
      run_error_hold();
      run_random(S, 4, 100, 1'b1);
      run_napot_sizes();
      @(negedge clk);
      $display("Test passed");
      $finish;
   end

endmodule
